// File: rtl/lpi_pkg.sv
/*
 * Link interface types for the burden-return bridge
 * Field widths, vector types and the request and response bundles
 */
package lpi_pkg;

  // ******************************
  // Widths
  // ******************************

  // Tag carried in the upper bits of each request word
  localparam int BW_BURDEN  = 8;
  localparam int BW_QPARCEL = 32;
  // Parcel returned by the slave, without the tag
  localparam int BW_YPARCEL = 4;

  localparam int BW_QDATA = BW_BURDEN + BW_QPARCEL;
  localparam int BW_YDATA = BW_BURDEN + BW_YPARCEL;

  // ******************************
  // Vector types
  // ******************************

  typedef logic [BW_BURDEN-1:0]  burden_t;
  typedef logic [BW_QPARCEL-1:0] qparcel_t;
  typedef logic [BW_YPARCEL-1:0] yparcel_t;

  // Burden sits above the parcel in both data words
  typedef logic [BW_QDATA-1:0] qdata_t;
  typedef logic [BW_YDATA-1:0] ydata_t;

  // Bit 0 is room for one item, bit 1 is room for two
  typedef logic [1:0] ready_lvl_t;

  // ******************************
  // Bundles
  // ******************************

  // Request channel, 43 bits
  typedef struct packed {
    logic   valid;
    logic   last;
    logic   resp_expected;
    qdata_t qdata;
  } lpi_req_t;

  // One response queue entry, 5 bits
  typedef struct packed {
    logic     last;
    yparcel_t yparcel;
  } lpi_resp_t;

endpackage

// File: rtl/lpi_fifo.sv
/*
 * Synchronous circular FIFO with shared enable and clear
 * Reports a two-level write ready and a not-empty read ready
 */
module lpi_fifo
  import lpi_pkg::*;
#(
  parameter int DATA_W = 8,
  parameter int DEPTH  = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  input  logic              clear,
  output ready_lvl_t        wready,
  input  logic              wrequest,
  input  logic [DATA_W-1:0] wdata,
  output logic              rready,
  input  logic              rrequest,
  output logic [DATA_W-1:0] rdata
);

  // A depth of one still needs a one-bit pointer
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;

  logic do_write;
  logic do_read;

  // Pointer advance with wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (int'(ptr) == DEPTH - 1) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // ******************************
  // Status
  // ******************************

  assign wready[0] = int'(count) < DEPTH;
  assign wready[1] = int'(count) <= DEPTH - 2;
  assign rready    = count != '0;

  // Requests beyond the available room or data are dropped
  assign do_write = enable & wrequest & wready[0];
  assign do_read  = enable & rrequest & rready;

  // ******************************
  // Pointers and count
  // ******************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clear) begin
      // Clear empties the queue whatever the enable
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_read) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_write && !clear) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // Head of queue, valid while rready is high
  assign rdata = mem[rd_ptr];

endmodule

// File: rtl/lpi_req_decode.sv
/*
 * Request decode for the burden-return bridge
 * Gates master ready and forwarded valid, and extracts burdens to queue
 */
module lpi_req_decode
  import lpi_pkg::*;
(
  input  lpi_req_t   q_in,
  input  ready_lvl_t q_ready_in,
  input  ready_lvl_t burden_room,
  input  logic       enable,
  output lpi_req_t   q_out,
  output ready_lvl_t q_ready_out,
  output logic       burden_push,
  output burden_t    burden
);

  logic q_accept;
  logic closes_txn;

  // ******************************
  // Ready and passthrough
  // ******************************

  // Master sees room only where both the slave and the burden queue have it
  assign q_ready_out = q_ready_in & burden_room;

  // Request goes through unchanged, valid held off while the burden queue is full
  always_comb begin
    q_out       = q_in;
    q_out.valid = q_in.valid & burden_room[0];
  end

  // ******************************
  // Burden capture
  // ******************************

  assign q_accept = q_in.valid & q_ready_out[0] & enable;

  // Only the final beat of a transaction that wants a reply leaves a burden
  assign closes_txn = q_in.last & q_in.resp_expected;

  assign burden_push = q_accept & closes_txn;

  // Tag is the top BW_BURDEN bits of the request word
  assign burden = q_in.qdata[BW_QDATA-1 -: BW_BURDEN];

endmodule

// File: rtl/lpi_resp_merge.sv
/*
 * Response merge for the burden-return bridge
 * Pairs the oldest response with the oldest burden and issues pop pulses
 */
module lpi_resp_merge
  import lpi_pkg::*;
(
  input  lpi_resp_t  resp_head,
  input  logic       resp_avail,
  input  burden_t    burden_head,
  input  logic       burden_avail,
  input  ready_lvl_t y_ready_master,
  input  logic       enable,
  output logic       y_valid_out,
  output logic       y_last_out,
  output ydata_t     y_data_out,
  output logic       resp_pop,
  output logic       burden_pop
);

  logic pair_ready;
  logic y_fire;

  // ******************************
  // Output word
  // ******************************

  // A response waits until its burden has been queued
  assign pair_ready = resp_avail & burden_avail;

  assign y_valid_out = pair_ready;
  assign y_last_out  = resp_head.last;

  // Burden above the returned parcel
  assign y_data_out = {burden_head, resp_head.yparcel};

  // ******************************
  // Pops
  // ******************************

  // Beat leaves when the master has room for at least one item
  assign y_fire = pair_ready & y_ready_master[0] & enable;

  assign resp_pop = y_fire;

  // One burden covers every beat of a multi-beat response
  assign burden_pop = y_fire & resp_head.last;

endmodule

// File: rtl/lpi_burden_bridge.sv
/*
 * Burden-return bridge top level
 * Passes requests through and rejoins stored burdens with slave responses
 */
module lpi_burden_bridge
  import lpi_pkg::*;
#(
  parameter int BURDEN_DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       enable,
  input  logic       clear,

  // Request from the master
  input  lpi_req_t   q_in,
  output ready_lvl_t q_ready_out,

  // Request towards the slave
  output lpi_req_t   q_out,
  input  ready_lvl_t q_ready_in,

  // Response from the slave
  input  lpi_resp_t  y_in,
  input  logic       y_valid_in,
  output ready_lvl_t y_ready_level,

  // Response towards the master
  output logic       y_valid_out,
  output logic       y_last_out,
  output ydata_t     y_data_out,
  input  ready_lvl_t y_ready_master
);

  // Burden queue
  ready_lvl_t burden_room;
  logic       burden_push;
  burden_t    burden_in;
  logic       burden_avail;
  logic       burden_pop;
  burden_t    burden_head;

  // Response queue
  logic       resp_avail;
  logic       resp_pop;
  lpi_resp_t  resp_head;

  // ******************************
  // Decode
  // ******************************

  lpi_req_decode u_req_decode (
    .q_in        (q_in),
    .q_ready_in  (q_ready_in),
    .burden_room (burden_room),
    .enable      (enable),
    .q_out       (q_out),
    .q_ready_out (q_ready_out),
    .burden_push (burden_push),
    .burden      (burden_in)
  );

  // ******************************
  // Queues
  // ******************************

  lpi_fifo #(
    .DATA_W (BW_BURDEN),
    .DEPTH  (BURDEN_DEPTH)
  ) u_burden_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable   (enable),
    .clear    (clear),
    .wready   (burden_room),
    .wrequest (burden_push),
    .wdata    (burden_in),
    .rready   (burden_avail),
    .rrequest (burden_pop),
    .rdata    (burden_head)
  );

  // Three entries cover the responses the slave may have in flight
  lpi_fifo #(
    .DATA_W ($bits(lpi_resp_t)),
    .DEPTH  (3)
  ) u_resp_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable   (enable),
    .clear    (clear),
    .wready   (y_ready_level),
    .wrequest (y_valid_in),
    .wdata    (y_in),
    .rready   (resp_avail),
    .rrequest (resp_pop),
    .rdata    (resp_head)
  );

  // ******************************
  // Merge
  // ******************************

  lpi_resp_merge u_resp_merge (
    .resp_head      (resp_head),
    .resp_avail     (resp_avail),
    .burden_head    (burden_head),
    .burden_avail   (burden_avail),
    .y_ready_master (y_ready_master),
    .enable         (enable),
    .y_valid_out    (y_valid_out),
    .y_last_out     (y_last_out),
    .y_data_out     (y_data_out),
    .resp_pop       (resp_pop),
    .burden_pop     (burden_pop)
  );

endmodule

// File: testbench/tb_lpi_burden_bridge.sv
/*
 * Testbench for the burden-return bridge
 * Random and directed traffic checked every cycle against a two-queue model
 */
module tb_lpi_burden_bridge
  import lpi_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int BURDEN_DEPTH = 4;
  localparam int RESP_DEPTH   = 3;
  localparam int WAIT_LIMIT   = 50;
  localparam int DRAIN_LIMIT  = 2000;

  logic       clk;
  logic       rst_n;
  logic       enable;
  logic       clear;
  lpi_req_t   q_in;
  ready_lvl_t q_ready_out;
  lpi_req_t   q_out;
  ready_lvl_t q_ready_in;
  lpi_resp_t  y_in;
  logic       y_valid_in;
  ready_lvl_t y_ready_level;
  logic       y_valid_out;
  logic       y_last_out;
  ydata_t     y_data_out;
  ready_lvl_t y_ready_master;

  // Reference model queues
  burden_t   model_burdens[$];
  lpi_resp_t model_resps[$];
  // Transactions whose last response beat the slave still owes
  int owed_last;
  int beats_out;

  // DUT outputs sampled at the falling edge
  logic       seen_y_valid;
  ready_lvl_t seen_q_ready;
  ready_lvl_t seen_y_level;

  lpi_burden_bridge #(
    .BURDEN_DEPTH (BURDEN_DEPTH)
  ) dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .clear          (clear),
    .q_in           (q_in),
    .q_ready_out    (q_ready_out),
    .q_out          (q_out),
    .q_ready_in     (q_ready_in),
    .y_in           (y_in),
    .y_valid_in     (y_valid_in),
    .y_ready_level  (y_ready_level),
    .y_valid_out    (y_valid_out),
    .y_last_out     (y_last_out),
    .y_data_out     (y_data_out),
    .y_ready_master (y_ready_master)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Room for one entry, and room for two
  function automatic ready_lvl_t room_level(int used, int depth);
    ready_lvl_t lvl;
    lvl[0] = used < depth;
    lvl[1] = used <= depth - 2;
    return lvl;
  endfunction

  task automatic report_failure(string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      report_failure($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h",
                               name, expected, actual));
    end
  endtask

  // ******************************
  // Model step and checks
  // ******************************

  // Checks outputs at the falling edge, then applies the coming rising edge to the model
  task automatic step_cycle();
    lpi_req_t   exp_q;
    ready_lvl_t b_room;
    ready_lvl_t r_room;
    ready_lvl_t exp_q_ready;
    logic       exp_y_valid;
    logic       q_accept;
    logic       y_fire;
    logic       resp_push;
    lpi_resp_t  head;
    @(negedge clk);
    b_room      = room_level(model_burdens.size(), BURDEN_DEPTH);
    r_room      = room_level(model_resps.size(), RESP_DEPTH);
    exp_q_ready = q_ready_in & b_room;
    exp_q       = q_in;
    exp_q.valid = q_in.valid & b_room[0];
    exp_y_valid = (model_resps.size() > 0) && (model_burdens.size() > 0);
    seen_y_valid = y_valid_out;
    seen_q_ready = q_ready_out;
    seen_y_level = y_ready_level;
    check_value("q_ready_out", 64'(exp_q_ready), 64'(q_ready_out));
    check_value("q_out", 64'(exp_q), 64'(q_out));
    check_value("y_ready_level", 64'(r_room), 64'(y_ready_level));
    check_value("y_valid_out", 64'(exp_y_valid), 64'(y_valid_out));
    if (exp_y_valid) begin
      head = model_resps[0];
      check_value("y_last_out", 64'(head.last), 64'(y_last_out));
      check_value("y_data_out", 64'({model_burdens[0], head.yparcel}), 64'(y_data_out));
    end
    q_accept  = q_in.valid & exp_q_ready[0] & enable;
    y_fire    = exp_y_valid & y_ready_master[0] & enable;
    resp_push = y_valid_in & r_room[0] & enable;
    if (clear) begin
      model_burdens.delete();
      model_resps.delete();
      owed_last = 0;
    end else begin
      if (y_fire) begin
        head = model_resps[0];
        model_resps.delete(0);
        // One burden per transaction, released on its last beat
        if (head.last) begin
          model_burdens.delete(0);
        end
        beats_out++;
      end
      if (q_accept && q_in.last && q_in.resp_expected) begin
        model_burdens.push_back(q_in.qdata[BW_QDATA-1 -: BW_BURDEN]);
        owed_last++;
      end
      if (resp_push) begin
        model_resps.push_back(y_in);
        if (y_in.last) begin
          owed_last--;
        end
      end
    end
    @(posedge clk);
  endtask

  // ******************************
  // Stimulus
  // ******************************

  function automatic lpi_req_t random_request();
    lpi_req_t r;
    r.valid         = ($urandom % 3) != 0;
    r.last          = ($urandom % 2) == 0;
    r.resp_expected = ($urandom % 4) != 0;
    r.qdata         = {burden_t'($urandom), qparcel_t'($urandom)};
    return r;
  endfunction

  // Slave answers only transactions that are owed and only within the ready level
  task automatic drive_slave(logic eager);
    lpi_resp_t r;
    if (owed_last > 0 && model_resps.size() < RESP_DEPTH &&
        (eager || ($urandom % 2) == 0)) begin
      r.last    = ($urandom % 3) == 0;
      r.yparcel = yparcel_t'($urandom);
      y_in       <= r;
      y_valid_in <= 1'b1;
    end else begin
      y_valid_in <= 1'b0;
    end
  endtask

  task automatic closing_request();
    lpi_req_t r;
    r               = random_request();
    r.valid         = 1'b1;
    r.last          = 1'b1;
    r.resp_expected = 1'b1;
    q_in <= r;
  endtask

  task automatic drain_queues();
    int n;
    n = 0;
    q_in           <= '0;
    y_ready_master <= 2'b11;
    while (model_burdens.size() != 0 || model_resps.size() != 0 || owed_last != 0) begin
      if (n >= DRAIN_LIMIT) begin
        report_failure("Timeout: the burden and response queues did not drain");
      end else begin
        drive_slave(1'b1);
        step_cycle();
        n++;
      end
    end
    y_valid_in <= 1'b0;
    step_cycle();
  endtask

  task automatic wait_y_valid();
    int n;
    n = 0;
    step_cycle();
    while (!seen_y_valid) begin
      if (n >= WAIT_LIMIT) begin
        report_failure("Timeout: y_valid_out never rose after a burden was queued");
      end else begin
        step_cycle();
        n++;
      end
    end
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial begin
    void'($urandom(18865));
    rst_n          = 1'b0;
    enable         = 1'b1;
    clear          = 1'b0;
    q_in           = '0;
    q_ready_in     = 2'b11;
    y_in           = '0;
    y_valid_in     = 1'b0;
    y_ready_master = 2'b11;
    owed_last      = 0;
    beats_out      = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Passthrough and burden return under random traffic
    for (int i = 0; i < 600; i++) begin
      q_in           <= random_request();
      q_ready_in     <= ready_lvl_t'($urandom);
      y_ready_master <= ready_lvl_t'($urandom);
      drive_slave(1'b0);
      step_cycle();
    end
    q_ready_in <= 2'b11;
    drain_queues();

    // Response before any burden is held back
    y_in       <= '{last: 1'b1, yparcel: yparcel_t'($urandom)};
    y_valid_in <= 1'b1;
    step_cycle();
    y_valid_in <= 1'b0;
    repeat (5) step_cycle();
    check_value("holdback_valid", 64'(0), 64'(seen_y_valid));
    closing_request();
    step_cycle();
    q_in <= '0;
    wait_y_valid();
    drain_queues();

    // Back-pressure fills both queues and stalls requests
    y_ready_master <= 2'b00;
    for (int i = 0; i < BURDEN_DEPTH + 4; i++) begin
      closing_request();
      drive_slave(1'b1);
      step_cycle();
    end
    check_value("burden_stall", 64'(0), 64'(seen_q_ready[0]));
    check_value("resp_full_level", 64'(0), 64'(seen_y_level));
    drain_queues();

    // Enable low freezes both queues
    y_ready_master <= 2'b00;
    for (int i = 0; i < 2; i++) begin
      closing_request();
      drive_slave(1'b1);
      step_cycle();
    end
    q_in           <= '0;
    y_valid_in     <= 1'b0;
    y_ready_master <= 2'b11;
    enable         <= 1'b0;
    for (int i = 0; i < 10; i++) begin
      q_in <= random_request();
      drive_slave(1'b1);
      step_cycle();
    end
    // Two burdens and one response stay queued, so the pair is offered but never taken
    check_value("frozen_y_valid", 64'(1), 64'(seen_y_valid));
    check_value("frozen_q_ready", 64'(2'b11), 64'(seen_q_ready));

    // Clear empties both queues
    q_in       <= '0;
    y_valid_in <= 1'b0;
    enable     <= 1'b1;
    clear      <= 1'b1;
    step_cycle();
    clear <= 1'b0;
    step_cycle();
    check_value("clear_y_valid", 64'(0), 64'(seen_y_valid));
    check_value("clear_q_ready", 64'(2'b11), 64'(seen_q_ready));
    check_value("clear_y_level", 64'(2'b11), 64'(seen_y_level));

    if (beats_out > 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      report_failure("No response beat left the bridge during the run");
    end
  end

endmodule

// File: vlog.f
rtl/lpi_pkg.sv
rtl/lpi_fifo.sv
rtl/lpi_req_decode.sv
rtl/lpi_resp_merge.sv
rtl/lpi_burden_bridge.sv
testbench/tb_lpi_burden_bridge.sv

// File: Makefile
# Verilator build for the burden-return bridge

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -j 0 -f vlog.f --top-module tb_lpi_burden_bridge -o tb_sim

run: build
	./obj_dir/tb_sim | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	verilator --lint-only -Wall -f vlog.f --top-module lpi_burden_bridge

clean:
	rm -rf obj_dir $(LOG)
